// File: Makefile
# Verilator build and run for the ring router testbench

VERILATOR ?= verilator
TOP       ?= ring_router_tb
FILELIST  ?= ring_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ring_router.f
source/net_msg_pkg.sv
source/router_cfg_pkg.sv
source/switch_alloc_if.sv
source/msg_queue.sv
source/ring_input_ctrl.sv
source/terminal_input_ctrl.sv
source/output_port_ctrl.sv
source/router_cfg_regs.sv
source/ring_router.sv
verification/ring_router_tb.sv

// File: source/msg_queue.sv
// --------------------------------------------------
// Four-entry valid/ready message queue for one input
// enq side faces the channel, deq side the input control
// --------------------------------------------------

`timescale 1ns/1ps

module msg_queue (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  enq_val,
  output logic                  enq_rdy,
  input  net_msg_pkg::net_msg_t enq_msg,
  output logic                  deq_val,
  input  logic                  deq_rdy,
  output net_msg_pkg::net_msg_t deq_msg
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  net_msg_t         entries [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             enq_fire;
  logic             deq_fire;

  // Full and empty come from the count alone
  assign enq_rdy  = (count != CNT_W'(QUEUE_DEPTH));
  assign deq_val  = (count != '0);
  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;
  assign deq_msg  = entries[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (enq_fire)
      entries[wr_ptr] <= enq_msg;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (enq_fire)
        wr_ptr <= wr_ptr + 1'b1;
      if (deq_fire)
        rd_ptr <= rd_ptr + 1'b1;
      if (enq_fire && !deq_fire)
        count <= count + 1'b1;
      else if (deq_fire && !enq_fire)
        count <= count - 1'b1;
    end
  end

  // A full queue has its write pointer wrapped onto the read pointer
  a_full_ptrs: assert property (@(posedge clk) disable iff (!arst_n)
    !enq_rdy |-> wr_ptr == rd_ptr);

  // An empty queue has both pointers on the same slot
  a_empty_ptrs: assert property (@(posedge clk) disable iff (!arst_n)
    !deq_val |-> wr_ptr == rd_ptr);

endmodule

// File: source/net_msg_pkg.sv
// --------------------------------------------------
// Network message format shared by every router block
// Import into a module body, scope it in port lists
// --------------------------------------------------

package net_msg_pkg;

  // Field widths
  localparam int SRCDEST_W = 3;
  localparam int OPAQUE_W  = 3;
  localparam int PAYLOAD_W = 32;

  // Destination sits in the top bits so routing reads it first
  typedef struct packed {
    logic [SRCDEST_W-1:0] dest;
    logic [SRCDEST_W-1:0] src;
    logic [OPAQUE_W-1:0]  opaque;
    logic [PAYLOAD_W-1:0] payload;
  } net_msg_t;

  // Flat width for the top-level ports
  localparam int NET_MSG_W = $bits(net_msg_t);

endpackage

// File: source/output_port_ctrl.sv
// --------------------------------------------------
// Round-robin arbiter and message select for one output
// The grant is held on an input while the output stalls
// --------------------------------------------------

`timescale 1ns/1ps

module output_port_ctrl #(
  parameter int OUT_IDX = 0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  switch_alloc_if.arbiter       alloc,
  input  net_msg_pkg::net_msg_t in_msgs [router_cfg_pkg::NUM_PORTS],
  output logic                  out_val,
  input  logic                  out_rdy,
  output net_msg_pkg::net_msg_t out_msg
);
  import router_cfg_pkg::*;

  localparam int IDX_W = $clog2(NUM_PORTS);

  port_mask_t       reqs;
  port_mask_t       arb_sel;
  port_mask_t       held_sel;
  port_mask_t       sel;
  logic             locked;
  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] sel_idx;

  assign reqs = alloc.req[OUT_IDX];

  // --------------------------------------------------
  // Arbitration
  // --------------------------------------------------

  // Walk from lowest to highest priority so the last hit wins
  always_comb
  begin
    int idx;
    arb_sel = '0;
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (int'(ptr) + k) % NUM_PORTS;
      if (reqs[idx])
        arb_sel = port_mask_t'(1) << idx;
    end
  end

  assign sel = locked ? held_sel : arb_sel;

  always_comb
  begin
    sel_idx = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (sel[i])
        sel_idx = IDX_W'(i);
    end
  end

  // Grant only on a transfer, so a stalled head stays in its queue
  assign out_val            = |(sel & reqs);
  assign out_msg            = in_msgs[sel_idx];
  assign alloc.gnt[OUT_IDX] = out_rdy ? (sel & reqs) : '0;

  // --------------------------------------------------
  // Pointer and grant lock
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ptr      <= '0;
      locked   <= 1'b0;
      held_sel <= '0;
    end
    else
    begin
      locked <= out_val && !out_rdy;
      if (out_val && !out_rdy)
        held_sel <= sel;
      // Winner drops to lowest priority
      if (out_val && out_rdy)
        ptr <= (sel_idx == IDX_W'(NUM_PORTS - 1)) ? '0 : sel_idx + 1'b1;
    end
  end

  // A stalled output keeps offering the same message
  a_hold_stall: assert property (@(posedge clk) disable iff (!arst_n)
    out_val && !out_rdy |=> out_val && $stable(out_msg));

  // After a transfer another waiting input gets the next turn
  a_rr_turn: assert property (@(posedge clk) disable iff (!arst_n)
    out_val && out_rdy |=> !(out_val && (sel == $past(sel)) && ((reqs & ~sel) != '0)));

endmodule

// File: source/ring_input_ctrl.sv
// --------------------------------------------------
// Route and request logic for a ring input port
// PORT picks the ring direction this instance serves
// --------------------------------------------------

`timescale 1ns/1ps

module ring_input_ctrl #(
  parameter int PORT = router_cfg_pkg::PORT_WEST
) (
  input  logic [net_msg_pkg::SRCDEST_W-1:0] dest,
  input  logic                              in_val,
  output logic                              in_rdy,
  input  logic [net_msg_pkg::SRCDEST_W-1:0] router_id,
  switch_alloc_if.requester                 alloc
);
  import router_cfg_pkg::*;

  port_mask_t req;

  // Local traffic ejects, the rest keeps going the same way
  always_comb
  begin
    req = '0;
    if (in_val)
    begin
      if (dest == router_id)
        req[PORT_TERM] = 1'b1;
      else
        req[PORT] = 1'b1;
    end
  end

  assign alloc.req[PORT] = req;
  assign in_rdy          = |(alloc.gnt[PORT] & req);

endmodule

// File: source/ring_router.sv
// --------------------------------------------------
// One ring router with west, terminal and east ports
// Flat valid/ready channels plus a small config port
// --------------------------------------------------

`timescale 1ns/1ps

module ring_router (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  in0_val,
  output logic                                  in0_rdy,
  input  logic [net_msg_pkg::NET_MSG_W-1:0]     in0_msg,
  input  logic                                  in1_val,
  output logic                                  in1_rdy,
  input  logic [net_msg_pkg::NET_MSG_W-1:0]     in1_msg,
  input  logic                                  in2_val,
  output logic                                  in2_rdy,
  input  logic [net_msg_pkg::NET_MSG_W-1:0]     in2_msg,
  output logic                                  out0_val,
  input  logic                                  out0_rdy,
  output logic [net_msg_pkg::NET_MSG_W-1:0]     out0_msg,
  output logic                                  out1_val,
  input  logic                                  out1_rdy,
  output logic [net_msg_pkg::NET_MSG_W-1:0]     out1_msg,
  output logic                                  out2_val,
  input  logic                                  out2_rdy,
  output logic [net_msg_pkg::NET_MSG_W-1:0]     out2_msg,
  input  logic [router_cfg_pkg::FREE_W-1:0]     west_free_one,
  input  logic [router_cfg_pkg::FREE_W-1:0]     west_free_two,
  input  logic [router_cfg_pkg::FREE_W-1:0]     east_free_one,
  input  logic [router_cfg_pkg::FREE_W-1:0]     east_free_two,
  input  logic                                  cfg_wr,
  input  logic                                  cfg_addr,
  input  logic [router_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
  output logic [router_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  logic [NUM_PORTS-1:0] enq_val;
  logic [NUM_PORTS-1:0] enq_rdy;
  net_msg_t             enq_msg [NUM_PORTS];
  logic [NUM_PORTS-1:0] deq_val;
  logic [NUM_PORTS-1:0] deq_rdy;
  net_msg_t             deq_msg [NUM_PORTS];
  logic [NUM_PORTS-1:0] out_val;
  logic [NUM_PORTS-1:0] out_rdy;
  net_msg_t             out_msg [NUM_PORTS];
  logic [SRCDEST_W-1:0] router_id;
  logic                 adaptive_en;

  // Rows by input, and rows by output
  switch_alloc_if in_alloc ();
  switch_alloc_if out_alloc ();

  // Flat channels to port-indexed arrays
  assign enq_val                    = {in2_val, in1_val, in0_val};
  assign {in2_rdy, in1_rdy, in0_rdy} = enq_rdy;
  assign enq_msg[PORT_WEST]         = in0_msg;
  assign enq_msg[PORT_TERM]         = in1_msg;
  assign enq_msg[PORT_EAST]         = in2_msg;
  assign out_rdy                    = {out2_rdy, out1_rdy, out0_rdy};
  assign {out2_val, out1_val, out0_val} = out_val;
  assign out0_msg                   = out_msg[PORT_WEST];
  assign out1_msg                   = out_msg[PORT_TERM];
  assign out2_msg                   = out_msg[PORT_EAST];

  // --------------------------------------------------
  // Queues, output control and matrix transpose
  // --------------------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port
    msg_queue in_queue (
      .clk     (clk),
      .arst_n  (arst_n),
      .enq_val (enq_val[p]),
      .enq_rdy (enq_rdy[p]),
      .enq_msg (enq_msg[p]),
      .deq_val (deq_val[p]),
      .deq_rdy (deq_rdy[p]),
      .deq_msg (deq_msg[p])
    );

    output_port_ctrl #(.OUT_IDX(p)) out_ctrl (
      .clk     (clk),
      .arst_n  (arst_n),
      .alloc   (out_alloc),
      .in_msgs (deq_msg),
      .out_val (out_val[p]),
      .out_rdy (out_rdy[p]),
      .out_msg (out_msg[p])
    );

    assign out_alloc.req[p] = {in_alloc.req[PORT_EAST][p],
                               in_alloc.req[PORT_TERM][p],
                               in_alloc.req[PORT_WEST][p]};
    assign in_alloc.gnt[p]  = {out_alloc.gnt[PORT_EAST][p],
                               out_alloc.gnt[PORT_TERM][p],
                               out_alloc.gnt[PORT_WEST][p]};
  end

  // --------------------------------------------------
  // Input control and configuration
  // --------------------------------------------------

  ring_input_ctrl #(.PORT(PORT_WEST)) west_in_ctrl (
    .dest      (deq_msg[PORT_WEST].dest),
    .in_val    (deq_val[PORT_WEST]),
    .in_rdy    (deq_rdy[PORT_WEST]),
    .router_id (router_id),
    .alloc     (in_alloc)
  );

  terminal_input_ctrl term_in_ctrl (
    .dest          (deq_msg[PORT_TERM].dest),
    .in_val        (deq_val[PORT_TERM]),
    .in_rdy        (deq_rdy[PORT_TERM]),
    .router_id     (router_id),
    .adaptive_en   (adaptive_en),
    .west_free_one (west_free_one),
    .west_free_two (west_free_two),
    .east_free_one (east_free_one),
    .east_free_two (east_free_two),
    .alloc         (in_alloc)
  );

  ring_input_ctrl #(.PORT(PORT_EAST)) east_in_ctrl (
    .dest      (deq_msg[PORT_EAST].dest),
    .in_val    (deq_val[PORT_EAST]),
    .in_rdy    (deq_rdy[PORT_EAST]),
    .router_id (router_id),
    .alloc     (in_alloc)
  );

  router_cfg_regs cfg_regs (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .router_id   (router_id),
    .adaptive_en (adaptive_en)
  );

endmodule

// File: source/router_cfg_pkg.sv
// --------------------------------------------------
// Router geometry, queue sizing and config register map
// --------------------------------------------------

package router_cfg_pkg;

  // Ring geometry
  localparam int NUM_ROUTERS = 8;
  localparam int NUM_PORTS   = 3;

  // Port indices, shared by inputs and outputs
  localparam int PORT_WEST = 0;
  localparam int PORT_TERM = 1;
  localparam int PORT_EAST = 2;

  // Input queue sizing
  localparam int QUEUE_DEPTH = 4;

  // Downstream free count, values 0 to 2
  localparam int FREE_W = 2;

  // Configuration register map
  localparam logic CFG_ADDR_ID   = 1'b0;
  localparam logic CFG_ADDR_MODE = 1'b1;
  localparam int   CFG_DATA_W    = 8;

  // One bit per port
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

// File: source/router_cfg_regs.sv
// --------------------------------------------------
// Router id and adaptive mode registers with readback
// --------------------------------------------------

`timescale 1ns/1ps

module router_cfg_regs (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  cfg_wr,
  input  logic                                  cfg_addr,
  input  logic [router_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
  output logic [router_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
  output logic [net_msg_pkg::SRCDEST_W-1:0]     router_id,
  output logic                                  adaptive_en
);
  import router_cfg_pkg::*;

  // Id resets to 0, adaptive routing starts enabled
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      router_id   <= '0;
      adaptive_en <= 1'b1;
    end
    else if (cfg_wr)
    begin
      case (cfg_addr)
        CFG_ADDR_ID:   router_id   <= cfg_wdata[$bits(router_id)-1:0];
        CFG_ADDR_MODE: adaptive_en <= cfg_wdata[0];
        default:       ;
      endcase
    end
  end

  // Zero-extended readback
  always_comb
  begin
    cfg_rdata = '0;
    case (cfg_addr)
      CFG_ADDR_ID:   cfg_rdata = CFG_DATA_W'(router_id);
      CFG_ADDR_MODE: cfg_rdata = CFG_DATA_W'(adaptive_en);
      default:       cfg_rdata = '0;
    endcase
  end

endmodule

// File: source/switch_alloc_if.sv
// --------------------------------------------------
// Request and grant matrix between input and output control
// --------------------------------------------------

`timescale 1ns/1ps

interface switch_alloc_if;
  import router_cfg_pkg::*;

  // Input-side instance: row is the input, bit is the output
  // Output-side instance: row is the output, bit is the input
  port_mask_t req [NUM_PORTS];
  port_mask_t gnt [NUM_PORTS];

  modport requester (output req, input gnt);
  modport arbiter (input req, output gnt);

endinterface

// File: source/terminal_input_ctrl.sv
// --------------------------------------------------
// Route logic for the terminal input port
// Minimal path, ties broken by downstream free space
// --------------------------------------------------

`timescale 1ns/1ps

module terminal_input_ctrl (
  input  logic [net_msg_pkg::SRCDEST_W-1:0] dest,
  input  logic                              in_val,
  output logic                              in_rdy,
  input  logic [net_msg_pkg::SRCDEST_W-1:0] router_id,
  input  logic                              adaptive_en,
  input  logic [router_cfg_pkg::FREE_W-1:0] west_free_one,
  input  logic [router_cfg_pkg::FREE_W-1:0] west_free_two,
  input  logic [router_cfg_pkg::FREE_W-1:0] east_free_one,
  input  logic [router_cfg_pkg::FREE_W-1:0] east_free_two,
  switch_alloc_if.requester                 alloc
);
  import router_cfg_pkg::*;

  localparam int HOP_W = $clog2(NUM_ROUTERS);

  logic [HOP_W-1:0]  west_hops;
  logic [HOP_W-1:0]  east_hops;
  logic [FREE_W:0]   west_sum;
  logic [FREE_W:0]   east_sum;
  port_mask_t        req;

  // Hop counts both ways round the ring
  assign west_hops = HOP_W'((NUM_ROUTERS + int'(router_id) - int'(dest)) % NUM_ROUTERS);
  assign east_hops = HOP_W'((NUM_ROUTERS + int'(dest) - int'(router_id)) % NUM_ROUTERS);

  // Free space over the next two routers on each side
  assign west_sum = {1'b0, west_free_one} + {1'b0, west_free_two};
  assign east_sum = {1'b0, east_free_one} + {1'b0, east_free_two};

  always_comb
  begin
    req = '0;
    if (in_val)
    begin
      if (dest == router_id)
        req[PORT_TERM] = 1'b1;
      else if (west_hops < east_hops)
        req[PORT_WEST] = 1'b1;
      else if (east_hops < west_hops)
        req[PORT_EAST] = 1'b1;
      else if (adaptive_en && (west_sum > east_sum))
        req[PORT_WEST] = 1'b1;
      else
        req[PORT_EAST] = 1'b1;
    end
  end

  assign alloc.req[PORT_TERM] = req;
  assign in_rdy               = |(alloc.gnt[PORT_TERM] & req);

endmodule

// File: verification/ring_router_tb.sv
// --------------------------------------------------
// Directed testbench for the ring router
// Drives all channels, checks outputs against queues
// --------------------------------------------------

`timescale 1ns/1ps

module ring_router_tb;
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 400 * CLK_PERIOD;

  logic                  clk;
  logic                  arst_n;
  logic                  in_val_a  [NUM_PORTS];
  logic                  in_rdy_a  [NUM_PORTS];
  net_msg_t              in_msg_a  [NUM_PORTS];
  logic                  out_val_a [NUM_PORTS];
  logic                  out_rdy_a [NUM_PORTS];
  net_msg_t              out_msg_a [NUM_PORTS];
  logic [FREE_W-1:0]     west_free_one;
  logic [FREE_W-1:0]     west_free_two;
  logic [FREE_W-1:0]     east_free_one;
  logic [FREE_W-1:0]     east_free_two;
  logic                  cfg_wr;
  logic                  cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  logic [31:0]           rng_state = 32'h88dc12e3;

  // Expected messages per output, in delivery order
  net_msg_t exp_q [NUM_PORTS][$];

  ring_router ring_router_i (
    .clk (clk), .arst_n (arst_n),
    .in0_val (in_val_a[0]), .in0_rdy (in_rdy_a[0]), .in0_msg (in_msg_a[0]),
    .in1_val (in_val_a[1]), .in1_rdy (in_rdy_a[1]), .in1_msg (in_msg_a[1]),
    .in2_val (in_val_a[2]), .in2_rdy (in_rdy_a[2]), .in2_msg (in_msg_a[2]),
    .out0_val (out_val_a[0]), .out0_rdy (out_rdy_a[0]), .out0_msg (out_msg_a[0]),
    .out1_val (out_val_a[1]), .out1_rdy (out_rdy_a[1]), .out1_msg (out_msg_a[1]),
    .out2_val (out_val_a[2]), .out2_rdy (out_rdy_a[2]), .out2_msg (out_msg_a[2]),
    .west_free_one (west_free_one), .west_free_two (west_free_two),
    .east_free_one (east_free_one), .east_free_two (east_free_two),
    .cfg_wr (cfg_wr), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_msg(input string name, input net_msg_t got, input net_msg_t exp);
    if (got !== exp)
      fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_cfg(input string name, input logic [CFG_DATA_W-1:0] got,
                           input logic [CFG_DATA_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic net_msg_t make_msg(input int dest, input int src, input int tag);
    net_msg_t m;
    rng_state = xorshift32(rng_state);
    m.dest    = SRCDEST_W'(dest);
    m.src     = SRCDEST_W'(src);
    m.opaque  = OPAQUE_W'(tag);
    m.payload = rng_state;
    return m;
  endfunction

  // Output monitor, sampled mid-cycle where outputs are settled
  always @(negedge clk)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (out_val_a[p] && out_rdy_a[p])
      begin
        if (exp_q[p].size() == 0)
          fail_run($sformatf("Unexpected message 0x%h on out%0d", out_msg_a[p], p));
        else
          check_msg($sformatf("out%0d_msg", p), out_msg_a[p], exp_q[p].pop_front());
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_run("Watchdog expired before the tests finished");
  end

  // --------------------------------------------------
  // Driver tasks, all start and end just after a rising edge
  // --------------------------------------------------

  task automatic apply_reset();
    arst_n = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      in_val_a[p]  = 1'b0;
      out_rdy_a[p] = 1'b1;
    end
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    arst_n = 1'b1;
  endtask

  task automatic write_cfg(input logic addr, input int data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = CFG_DATA_W'(data);
    @(posedge clk);
    #(DRIVE_DELAY);
    cfg_wr = 1'b0;
  endtask

  task automatic read_cfg(input logic addr, input int exp);
    cfg_addr = addr;
    @(negedge clk);
    check_cfg("cfg_rdata", cfg_rdata, CFG_DATA_W'(exp));
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic send_msg(input int port, input net_msg_t m);
    in_val_a[port] = 1'b1;
    in_msg_a[port] = m;
    @(negedge clk);
    while (!in_rdy_a[port])
      @(negedge clk);
    @(posedge clk);
    #(DRIVE_DELAY);
    in_val_a[port] = 1'b0;
  endtask

  task automatic send_expect(input int in_port, input int out_port, input net_msg_t m);
    exp_q[out_port].push_back(m);
    send_msg(in_port, m);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
      @(negedge clk);
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic set_free(input int w1, input int w2, input int e1, input int e2);
    west_free_one = FREE_W'(w1);
    west_free_two = FREE_W'(w2);
    east_free_one = FREE_W'(e1);
    east_free_two = FREE_W'(e2);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------

  task automatic reset_and_config();
    read_cfg(CFG_ADDR_ID, 0);
    read_cfg(CFG_ADDR_MODE, 1);
    write_cfg(CFG_ADDR_ID, 5);
    write_cfg(CFG_ADDR_MODE, 0);
    read_cfg(CFG_ADDR_ID, 5);
    read_cfg(CFG_ADDR_MODE, 0);
  endtask

  task automatic ring_traffic();
    int west_dests [5] = '{3, 0, 3, 6, 1};
    int west_outs  [5] = '{1, 0, 1, 0, 0};
    int east_dests [5] = '{3, 5, 3, 7, 2};
    int east_outs  [5] = '{1, 2, 1, 2, 2};
    write_cfg(CFG_ADDR_ID, 3);
    for (int i = 0; i < 5; i++)
      send_expect(PORT_WEST, west_outs[i], make_msg(west_dests[i], 2, i));
    wait_drain();
    for (int i = 0; i < 5; i++)
      send_expect(PORT_EAST, east_outs[i], make_msg(east_dests[i], 4, i));
    wait_drain();
  endtask

  task automatic terminal_minimal();
    int dests [6] = '{1, 2, 4, 5, 6, 3};
    int outs  [6] = '{0, 0, 2, 2, 2, 1};
    for (int i = 0; i < 6; i++)
      send_expect(PORT_TERM, outs[i], make_msg(dests[i], 3, i));
    wait_drain();
  endtask

  // Dest 7 from id 3 is four hops either way
  task automatic adaptive_tie();
    write_cfg(CFG_ADDR_MODE, 1);
    set_free(2, 2, 1, 0);
    send_expect(PORT_TERM, PORT_WEST, make_msg(7, 3, 0));
    wait_drain();
    set_free(1, 1, 2, 0);
    send_expect(PORT_TERM, PORT_EAST, make_msg(7, 3, 1));
    wait_drain();
    write_cfg(CFG_ADDR_MODE, 0);
    set_free(2, 2, 0, 0);
    send_expect(PORT_TERM, PORT_EAST, make_msg(7, 3, 2));
    wait_drain();
  endtask

  task automatic back_pressure();
    net_msg_t first;
    net_msg_t m;
    out_rdy_a[PORT_WEST] = 1'b0;
    first = make_msg(0, 4, 0);
    send_expect(PORT_WEST, PORT_WEST, first);
    for (int i = 1; i < QUEUE_DEPTH; i++)
      send_expect(PORT_WEST, PORT_WEST, make_msg(0, 4, i));
    @(negedge clk);
    if (in_rdy_a[PORT_WEST])
      fail_run("in0_rdy still high with a full queue and out0 stalled");
    @(posedge clk);
    #(DRIVE_DELAY);
    m = make_msg(0, 4, QUEUE_DEPTH);
    fork
      send_expect(PORT_WEST, PORT_WEST, m);
      begin
        repeat (4)
        begin
          @(negedge clk);
          if (in_rdy_a[PORT_WEST] || !out_val_a[PORT_WEST])
            fail_run("in0 ready or out0 idle during the stall");
          check_msg("out0_msg", out_msg_a[PORT_WEST], first);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        out_rdy_a[PORT_WEST] = 1'b1;
      end
    join
    wait_drain();
  endtask

  // Fresh reset so the out1 arbiter starts with input 0
  task automatic contention();
    net_msg_t from_west [QUEUE_DEPTH];
    net_msg_t from_east [QUEUE_DEPTH];
    apply_reset();
    write_cfg(CFG_ADDR_ID, 3);
    out_rdy_a[PORT_TERM] = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++)
    begin
      from_west[i] = make_msg(3, 2, i);
      from_east[i] = make_msg(3, 4, i);
      exp_q[PORT_TERM].push_back(from_west[i]);
      exp_q[PORT_TERM].push_back(from_east[i]);
    end
    fork
      for (int i = 0; i < QUEUE_DEPTH; i++)
        send_msg(PORT_WEST, from_west[i]);
      for (int j = 0; j < QUEUE_DEPTH; j++)
        send_msg(PORT_EAST, from_east[j]);
    join
    out_rdy_a[PORT_TERM] = 1'b1;
    wait_drain();
  endtask

  initial
  begin
    arst_n = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      in_val_a[p]  = 1'b0;
      in_msg_a[p]  = '0;
      out_rdy_a[p] = 1'b1;
    end
    set_free(0, 0, 0, 0);
    cfg_wr    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    apply_reset();
    reset_and_config();
    ring_traffic();
    terminal_minimal();
    adaptive_tie();
    back_pressure();
    contention();
    repeat (4) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule
